// ==== list.f ====
rtl/cluster_pkg.sv
rtl/access_check.sv
rtl/scratchpad.sv
rtl/cluster_csr.sv
rtl/bus_arbiter.sv
rtl/cluster_top.sv
verification/tb_cluster.sv

// ==== rtl/access_check.sv ====
// Window decode and privilege/protection check for the address the arbiter is about to grant
`timescale 1ns/1ps

module access_check (
    input  cluster_pkg::addr_t cand_addr,
    input  logic               priv,
    input  cluster_pkg::addr_t mpu_base,
    input  cluster_pkg::addr_t mpu_limit,
    output logic               is_spad,
    output logic               fault
);

    logic is_mmio;
    logic is_hbw;
    logic region_en;
    logic out_of_region;

    // ======================================
    // Window decode
    // ======================================
    assign is_spad = (cand_addr[63:32] == cluster_pkg::spad_hi);
    assign is_mmio = (cand_addr[63:32] == cluster_pkg::mmio_hi);

    // High-bandwidth window lives at the top of the low 4 GiB
    assign is_hbw  = (cand_addr[63:32] == 32'd0) &&
                     (cand_addr[31:20] >= cluster_pkg::hbw_min);

    // ======================================
    // Protection region
    // ======================================
    // Region is off while limit does not exceed base
    assign region_en     = (mpu_limit > mpu_base);
    assign out_of_region = (cand_addr < mpu_base) || (cand_addr >= mpu_limit);

    // Only user mode faults, and never on scratchpad or I/O
    assign fault = priv && !is_spad && !is_mmio &&
                   (is_hbw || (region_en && out_of_region));

endmodule

// ==== rtl/bus_arbiter.sv ====
// Round-robin arbiter, steering each granted core request to a fault reply, scratchpad or bus
`timescale 1ns/1ps

module bus_arbiter (
    input  logic                                            clk,
    input  logic                                            cl_rst,
    // Core side
    input  cluster_pkg::core_mask_t                         core_valid,
    input  cluster_pkg::addr_t [cluster_pkg::num_cores-1:0] core_addr,
    input  cluster_pkg::data_t [cluster_pkg::num_cores-1:0] core_wdata,
    input  cluster_pkg::core_mask_t                         core_wen,
    input  cluster_pkg::size_t [cluster_pkg::num_cores-1:0] core_size,
    output cluster_pkg::core_mask_t                         core_ready,
    output cluster_pkg::data_t [cluster_pkg::num_cores-1:0] core_rdata,
    output cluster_pkg::core_mask_t                         core_fault,
    // External bus
    output logic                                            bus_valid,
    output cluster_pkg::addr_t                              bus_addr,
    output cluster_pkg::data_t                              bus_wdata,
    output logic                                            bus_wen,
    output cluster_pkg::size_t                              bus_size,
    input  cluster_pkg::data_t                              bus_rdata,
    input  logic                                            bus_ready,
    // Access check
    output cluster_pkg::addr_t                              cand_addr,
    input  logic                                            is_spad,
    input  logic                                            fault,
    output logic                                            fault_taken,
    // Scratchpad
    output logic                                            spad_en,
    output logic                                            spad_wen,
    output cluster_pkg::spad_idx_t                          spad_idx,
    output cluster_pkg::data_t                              spad_wdata,
    input  cluster_pkg::data_t                              spad_rdata
);

    cluster_pkg::arb_state_t state;
    cluster_pkg::core_idx_t  arb_last;
    cluster_pkg::core_idx_t  arb_grant;
    cluster_pkg::core_idx_t  arb_next;
    cluster_pkg::core_mask_t eligible;
    logic                    arb_any;
    // Set in the second scratchpad cycle, when the read word is available
    logic                    spad_wait;
    logic                    grant_now;

    // A core finishing this cycle still shows valid, so skip it
    assign eligible  = core_valid & ~core_ready;
    assign grant_now = (state == cluster_pkg::arb_idle) && arb_any;

    // Search starts one past the last granted core and wraps
    always_comb begin
        cluster_pkg::core_idx_t cand;
        arb_next = arb_last;
        arb_any  = 1'b0;
        for (int i = 1; i <= cluster_pkg::num_cores; i++) begin
            cand = arb_last + cluster_pkg::core_idx_t'(i);
            if (!arb_any && eligible[cand]) begin
                arb_next = cand;
                arb_any  = 1'b1;
            end
        end
    end

    assign cand_addr  = core_addr[arb_next];

    // Granted core holds its request, so the memory sees stable fields
    assign spad_en    = (state == cluster_pkg::arb_spad) && !spad_wait;
    assign spad_wen   = core_wen[arb_grant];
    assign spad_idx   = core_addr[arb_grant][9:3];
    assign spad_wdata = core_wdata[arb_grant];

    // ======================================
    // Transaction FSM
    // ======================================
    always_ff @(posedge clk) begin
        if (cl_rst) begin
            state       <= cluster_pkg::arb_idle;
            arb_last    <= '0;
            arb_grant   <= '0;
            spad_wait   <= 1'b0;
            bus_valid   <= 1'b0;
            core_ready  <= '0;
            core_fault  <= '0;
            fault_taken <= 1'b0;
        end else begin
            core_ready  <= '0;
            core_fault  <= '0;
            fault_taken <= 1'b0;
            case (state)
                cluster_pkg::arb_idle: begin
                    if (arb_any) begin
                        arb_grant <= arb_next;
                        if (fault) begin
                            // Rejected in the grant cycle itself
                            core_ready[arb_next] <= 1'b1;
                            core_fault[arb_next] <= 1'b1;
                            fault_taken          <= 1'b1;
                            arb_last             <= arb_next;
                        end else if (is_spad) begin
                            state <= cluster_pkg::arb_spad;
                        end else begin
                            state     <= cluster_pkg::arb_ext;
                            bus_valid <= 1'b1;
                        end
                    end
                end
                cluster_pkg::arb_spad: begin
                    spad_wait <= ~spad_wait;
                    if (spad_wait) begin
                        core_ready[arb_grant] <= 1'b1;
                        arb_last              <= arb_grant;
                        state                 <= cluster_pkg::arb_idle;
                    end
                end
                cluster_pkg::arb_ext: begin
                    // Other cores stall for as long as the bus holds off
                    if (bus_ready) begin
                        bus_valid             <= 1'b0;
                        core_ready[arb_grant] <= 1'b1;
                        arb_last              <= arb_grant;
                        state                 <= cluster_pkg::arb_idle;
                    end
                end
                default: state <= cluster_pkg::arb_idle;
            endcase
        end
    end

    // Bus fields and read data
    always_ff @(posedge clk) begin
        if (grant_now) begin
            if (fault) begin
                core_rdata[arb_next] <= '0;
            end else if (!is_spad) begin
                bus_addr  <= core_addr[arb_next];
                bus_wdata <= core_wdata[arb_next];
                bus_wen   <= core_wen[arb_next];
                bus_size  <= core_size[arb_next];
            end
        end else if (state == cluster_pkg::arb_spad && spad_wait) begin
            core_rdata[arb_grant] <= spad_rdata;
        end else if (state == cluster_pkg::arb_ext && bus_ready) begin
            core_rdata[arb_grant] <= bus_rdata;
        end
    end

endmodule

// ==== rtl/cluster_csr.sv ====
// Cluster control registers, hardware barrier and per-core CSR read muxes
`timescale 1ns/1ps

module cluster_csr (
    input  logic                                                clk,
    input  logic                                                cl_rst,
    input  cluster_pkg::csr_addr_t [cluster_pkg::num_cores-1:0] csr_addr,
    input  cluster_pkg::core_mask_t                             csr_wen,
    input  cluster_pkg::data_t     [cluster_pkg::num_cores-1:0] csr_wdata,
    output cluster_pkg::data_t     [cluster_pkg::num_cores-1:0] csr_rdata,
    input  logic                                                fault_taken,
    output logic                                                barrier_done,
    // 0 is supervisor, 1 is user
    output logic                                                priv,
    output cluster_pkg::addr_t                                  mpu_base,
    output cluster_pkg::addr_t                                  mpu_limit
);

    cluster_pkg::core_mask_t arrive_mask;
    logic                    barrier_full;

    assign barrier_full = &arrive_mask;

    // ======================================
    // Privilege and protection registers
    // ======================================
    always_ff @(posedge clk) begin
        if (cl_rst) begin
            priv      <= 1'b0;
            mpu_base  <= '0;
            mpu_limit <= '0;
        end else begin
            // Ascending loop, so the highest-indexed writer lands last
            for (int i = 0; i < cluster_pkg::num_cores; i++) begin
                if (csr_wen[i] && !priv) begin
                    case (csr_addr[i])
                        cluster_pkg::csr_cl_priv:   priv      <= csr_wdata[i][0];
                        cluster_pkg::csr_mpu_base:  mpu_base  <= csr_wdata[i];
                        cluster_pkg::csr_mpu_limit: mpu_limit <= csr_wdata[i];
                        default: ;
                    endcase
                end
            end
            // Fault drops to supervisor for the trap, over any write
            if (fault_taken) begin
                priv <= 1'b0;
            end
        end
    end

    // ======================================
    // Hardware barrier
    // ======================================
    always_ff @(posedge clk) begin
        if (cl_rst) begin
            arrive_mask  <= '0;
            barrier_done <= 1'b0;
        end else begin
            barrier_done <= barrier_full;
            if (barrier_full) begin
                arrive_mask <= '0;
            end
            // An arrival in the release cycle is kept for the next round
            for (int i = 0; i < cluster_pkg::num_cores; i++) begin
                if (csr_wen[i] && csr_addr[i] == cluster_pkg::csr_barrier_arrive) begin
                    arrive_mask[i] <= 1'b1;
                end
            end
        end
    end

    // Each core reads through its own mux
    always_comb begin
        for (int i = 0; i < cluster_pkg::num_cores; i++) begin
            case (csr_addr[i])
                cluster_pkg::csr_cl_priv:        csr_rdata[i] = {63'd0, priv};
                cluster_pkg::csr_mpu_base:       csr_rdata[i] = mpu_base;
                cluster_pkg::csr_mpu_limit:      csr_rdata[i] = mpu_limit;
                cluster_pkg::csr_barrier_arrive: csr_rdata[i] = {60'd0, arrive_mask};
                cluster_pkg::csr_barrier_status: begin
                    csr_rdata[i] = {59'd0, barrier_done, arrive_mask};
                end
                default:                         csr_rdata[i] = '0;
            endcase
        end
    end

endmodule

// ==== rtl/cluster_pkg.sv ====
// Cluster widths, address windows, CSR map and arbiter states, referenced by scoped names
package cluster_pkg;

    // ======================================
    // Cluster size and widths
    // ======================================
    localparam int num_cores = 4;

    typedef logic [1:0]           core_idx_t;
    typedef logic [num_cores-1:0] core_mask_t;
    typedef logic [63:0]          addr_t;
    typedef logic [63:0]          data_t;
    typedef logic [1:0]           size_t;
    typedef logic [7:0]           csr_addr_t;
    // Word index taken from addr[9:3]
    typedef logic [6:0]           spad_idx_t;

    // ======================================
    // Address windows
    // ======================================
    localparam int spad_depth = 128;

    // Upper 32 address bits of the scratchpad
    localparam logic [31:0] spad_hi = 32'hFFFF_FF00;
    // I/O window, always allowed
    localparam logic [31:0] mmio_hi = 32'hFFFF_FF01;
    // High-bandwidth window start in addr[31:20], only when addr[63:32] is zero
    localparam logic [11:0] hbw_min = 12'hFFD;

    // ======================================
    // Cluster CSR map
    // ======================================
    localparam csr_addr_t csr_cl_priv        = 8'h80;
    localparam csr_addr_t csr_mpu_base       = 8'h81;
    localparam csr_addr_t csr_mpu_limit      = 8'h82;
    localparam csr_addr_t csr_barrier_arrive = 8'h83;
    localparam csr_addr_t csr_barrier_status = 8'h84;

    // Arbiter transaction states
    typedef enum logic [1:0] {
        arb_idle,
        arb_spad,
        arb_ext
    } arb_state_t;

endpackage

// ==== rtl/cluster_top.sv ====
// Cluster shared bus top level, joining the arbiter, access check, scratchpad and control registers
`timescale 1ns/1ps

module cluster_top (
    input  logic                                                clk,
    input  logic                                                cl_rst,
    // Per-core bus requests
    input  cluster_pkg::core_mask_t                             core_valid,
    input  cluster_pkg::core_mask_t                             core_wen,
    input  cluster_pkg::addr_t     [cluster_pkg::num_cores-1:0] core_addr,
    input  cluster_pkg::data_t     [cluster_pkg::num_cores-1:0] core_wdata,
    input  cluster_pkg::size_t     [cluster_pkg::num_cores-1:0] core_size,
    output cluster_pkg::core_mask_t                             core_ready,
    output cluster_pkg::core_mask_t                             core_fault,
    output cluster_pkg::data_t     [cluster_pkg::num_cores-1:0] core_rdata,
    // Per-core cluster CSR ports
    input  cluster_pkg::csr_addr_t [cluster_pkg::num_cores-1:0] csr_addr,
    input  cluster_pkg::core_mask_t                             csr_wen,
    input  cluster_pkg::data_t     [cluster_pkg::num_cores-1:0] csr_wdata,
    output cluster_pkg::data_t     [cluster_pkg::num_cores-1:0] csr_rdata,
    // External bus
    output logic                                                bus_valid,
    output logic                                                bus_wen,
    output cluster_pkg::addr_t                                  bus_addr,
    output cluster_pkg::data_t                                  bus_wdata,
    output cluster_pkg::size_t                                  bus_size,
    input  cluster_pkg::data_t                                  bus_rdata,
    input  logic                                                bus_ready,
    output logic                                                barrier_done
);

    cluster_pkg::addr_t     cand_addr;
    logic                   is_spad;
    logic                   fault;
    logic                   fault_taken;
    logic                   spad_en;
    logic                   spad_wen;
    cluster_pkg::spad_idx_t spad_idx;
    cluster_pkg::data_t     spad_wdata;
    cluster_pkg::data_t     spad_rdata;
    logic                   priv;
    cluster_pkg::addr_t     mpu_base;
    cluster_pkg::addr_t     mpu_limit;

    bus_arbiter u_arbiter (
        .clk(clk), .cl_rst(cl_rst),
        .core_valid(core_valid), .core_addr(core_addr), .core_wdata(core_wdata),
        .core_wen(core_wen), .core_size(core_size),
        .core_ready(core_ready), .core_rdata(core_rdata), .core_fault(core_fault),
        .bus_valid(bus_valid), .bus_addr(bus_addr), .bus_wdata(bus_wdata),
        .bus_wen(bus_wen), .bus_size(bus_size),
        .bus_rdata(bus_rdata), .bus_ready(bus_ready),
        .cand_addr(cand_addr), .is_spad(is_spad), .fault(fault),
        .fault_taken(fault_taken),
        .spad_en(spad_en), .spad_wen(spad_wen), .spad_idx(spad_idx),
        .spad_wdata(spad_wdata), .spad_rdata(spad_rdata)
    );

    access_check u_access_check (
        .cand_addr(cand_addr), .priv(priv),
        .mpu_base(mpu_base), .mpu_limit(mpu_limit),
        .is_spad(is_spad), .fault(fault)
    );

    scratchpad u_scratchpad (
        .clk(clk), .en(spad_en), .wen(spad_wen), .idx(spad_idx),
        .wdata(spad_wdata), .rdata(spad_rdata)
    );

    cluster_csr u_csr (
        .clk(clk), .cl_rst(cl_rst),
        .csr_addr(csr_addr), .csr_wen(csr_wen), .csr_wdata(csr_wdata),
        .csr_rdata(csr_rdata),
        .fault_taken(fault_taken), .barrier_done(barrier_done),
        .priv(priv), .mpu_base(mpu_base), .mpu_limit(mpu_limit)
    );

endmodule

// ==== rtl/scratchpad.sv ====
// Single-port scratchpad memory with a registered read that returns the word before a write
`timescale 1ns/1ps

module scratchpad (
    input  logic                   clk,
    input  logic                   en,
    input  logic                   wen,
    input  cluster_pkg::spad_idx_t idx,
    input  cluster_pkg::data_t     wdata,
    output cluster_pkg::data_t     rdata
);

    cluster_pkg::data_t mem [cluster_pkg::spad_depth];

    // Read and write share the edge, so a write returns the old content
    always_ff @(posedge clk) begin
        if (en) begin
            rdata <= mem[idx];
            if (wen) begin
                mem[idx] <= wdata;
            end
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the cluster testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f list.f --top-module tb_cluster -o sim_cluster
if [ $? -ne 0 ]; then
    echo "Compile failed"
    exit 1
fi

./obj_dir/sim_cluster > sim.log
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TESTS PASSED" sim.log; then
    exit 0
fi
exit 1

// ==== verification/tb_cluster.sv ====
// Testbench for cluster_top with random traffic, an external bus responder and a reference model
`timescale 1ns/1ps

module tb_cluster;

    // ========================================
    // Test lengths and run limit
    // ========================================
    localparam int spad_words = 16;
    localparam int spad_reads = 24;
    localparam int ext_ops    = 24;
    localparam int rr_rounds  = 6;
    // Rough cycle cost of each test
    localparam int test_len   = (spad_words + spad_reads) * 6 + ext_ops * 10 +
                                rr_rounds * 50 + 80 + 60;
    localparam int max_cycles = 4 * test_len + 200;

    logic                                                clk;
    logic                                                cl_rst;
    cluster_pkg::core_mask_t                             core_valid;
    cluster_pkg::core_mask_t                             core_wen;
    cluster_pkg::addr_t     [cluster_pkg::num_cores-1:0] core_addr;
    cluster_pkg::data_t     [cluster_pkg::num_cores-1:0] core_wdata;
    cluster_pkg::size_t     [cluster_pkg::num_cores-1:0] core_size;
    cluster_pkg::core_mask_t                             core_ready;
    cluster_pkg::core_mask_t                             core_fault;
    cluster_pkg::data_t     [cluster_pkg::num_cores-1:0] core_rdata;
    cluster_pkg::csr_addr_t [cluster_pkg::num_cores-1:0] csr_addr;
    cluster_pkg::core_mask_t                             csr_wen;
    cluster_pkg::data_t     [cluster_pkg::num_cores-1:0] csr_wdata;
    cluster_pkg::data_t     [cluster_pkg::num_cores-1:0] csr_rdata;
    logic                                                bus_valid;
    logic                                                bus_wen;
    cluster_pkg::addr_t                                  bus_addr;
    cluster_pkg::data_t                                  bus_wdata;
    cluster_pkg::size_t                                  bus_size;
    cluster_pkg::data_t                                  bus_rdata;
    logic                                                bus_ready;
    logic                                                barrier_done;

    logic [31:0]            rng;
    // Separate stream for the responder, so stimulus draws do not race with it
    logic [31:0]            bus_rng;
    int                     cycles;
    int                     errors;
    int                     tests_failed;
    int                     bus_delay;
    int                     bus_count;
    int                     done_count;
    cluster_pkg::core_idx_t rr_last;
    cluster_pkg::data_t     spad_ref [spad_words];
    cluster_pkg::data_t     ext_mem  [cluster_pkg::addr_t];
    cluster_pkg::addr_t     bus_addr_q [$];
    cluster_pkg::data_t     seen_wdata;
    logic                   seen_wen;
    cluster_pkg::size_t     seen_size;

    cluster_top u_dut (
        .clk(clk), .cl_rst(cl_rst),
        .core_valid(core_valid), .core_wen(core_wen), .core_addr(core_addr),
        .core_wdata(core_wdata), .core_size(core_size),
        .core_ready(core_ready), .core_fault(core_fault), .core_rdata(core_rdata),
        .csr_addr(csr_addr), .csr_wen(csr_wen), .csr_wdata(csr_wdata),
        .csr_rdata(csr_rdata),
        .bus_valid(bus_valid), .bus_wen(bus_wen), .bus_addr(bus_addr),
        .bus_wdata(bus_wdata), .bus_size(bus_size),
        .bus_rdata(bus_rdata), .bus_ready(bus_ready),
        .barrier_done(barrier_done)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    // Content of a bus word that was never written
    function automatic cluster_pkg::data_t ext_word(cluster_pkg::addr_t a);
        if (ext_mem.exists(a)) begin
            return ext_mem[a];
        end
        return a ^ {a[31:0], a[63:32]} ^ 64'h5bd1_e995_c3a7_0f11;
    endfunction

    task automatic check_value(string name, cluster_pkg::data_t got, cluster_pkg::data_t exp);
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic report(string name, int err_before);
        if (errors == err_before) begin
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", name, errors - err_before);
        end
    endtask

    // One core request, held until its ready pulse; lat counts cycles from the drive edge
    task automatic do_access(input cluster_pkg::core_idx_t c, input cluster_pkg::addr_t a,
                             input cluster_pkg::data_t wd, input logic we,
                             input cluster_pkg::size_t sz, output cluster_pkg::data_t rd,
                             output logic flt, output int lat);
        @(posedge clk);
        core_valid[c] <= 1'b1;
        core_addr[c]  <= a;
        core_wdata[c] <= wd;
        core_wen[c]   <= we;
        core_size[c]  <= sz;
        lat = 0;
        @(negedge clk);
        while (!core_ready[c]) begin
            @(negedge clk);
            lat++;
        end
        rd  = core_rdata[c];
        flt = core_fault[c];
        rr_last = c;
        @(posedge clk);
        core_valid[c] <= 1'b0;
    endtask

    task automatic csr_write(cluster_pkg::core_idx_t c, cluster_pkg::csr_addr_t a,
                             cluster_pkg::data_t d);
        @(posedge clk);
        csr_addr[c]  <= a;
        csr_wdata[c] <= d;
        csr_wen[c]   <= 1'b1;
        @(posedge clk);
        csr_wen[c]   <= 1'b0;
    endtask

    task automatic csr_read(cluster_pkg::core_idx_t c, cluster_pkg::csr_addr_t a,
                            output cluster_pkg::data_t d);
        @(posedge clk);
        csr_addr[c] <= a;
        @(negedge clk);
        d = csr_rdata[c];
    endtask

    // ========================================
    // External bus responder
    // ========================================
    always @(posedge clk) begin
        if (cl_rst) begin
            bus_ready <= 1'b0;
            bus_delay = 0;
        end else if (bus_valid && !bus_ready) begin
            if (bus_delay == 0) begin
                bus_ready <= 1'b1;
                bus_addr_q.push_back(bus_addr);
                seen_wdata = bus_wdata;
                seen_wen   = bus_wen;
                seen_size  = bus_size;
                bus_count++;
                if (bus_wen) begin
                    ext_mem[bus_addr] = bus_wdata;
                    bus_rdata <= '0;
                end else begin
                    bus_rdata <= ext_word(bus_addr);
                end
            end else begin
                bus_delay--;
            end
        end else begin
            bus_ready <= 1'b0;
            bus_rng   = xorshift(bus_rng);
            bus_delay = int'(bus_rng % 32'd4);
        end
    end

    always @(negedge clk) begin
        if (barrier_done) begin
            done_count++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > max_cycles) begin
            $display("Timeout: run passed %0d cycles without finishing", max_cycles);
            $display("TESTS FAILED");
            $finish;
        end
    end

    initial begin
        cluster_pkg::data_t     rd;
        cluster_pkg::data_t     exp;
        cluster_pkg::addr_t     a;
        cluster_pkg::addr_t     rr_addr [cluster_pkg::num_cores];
        cluster_pkg::addr_t     exp_q [$];
        cluster_pkg::core_idx_t c;
        cluster_pkg::core_idx_t order [cluster_pkg::num_cores];
        logic                   flt;
        logic                   we;
        int                     lat;
        int                     err0;
        int                     bus0;
        int                     j;
        int                     k;
        int                     t;

        clk = 1'b0;
        cl_rst = 1'b1;
        core_valid = '0;
        core_wen = '0;
        core_addr = '0;
        core_wdata = '0;
        core_size = '0;
        csr_addr = '0;
        csr_wen = '0;
        csr_wdata = '0;
        bus_rdata = '0;
        bus_ready = 1'b0;
        rng = 32'h2b0115e2;
        bus_rng = 32'h2b0115e2;
        cycles = 0;
        errors = 0;
        tests_failed = 0;
        bus_count = 0;
        done_count = 0;
        rr_last = '0;
        repeat (2) @(posedge clk);
        cl_rst <= 1'b0;

        // Test 1: scratchpad writes then reads
        err0 = errors;
        bus0 = bus_count;
        for (int i = 0; i < spad_words; i++) begin
            spad_ref[i] = {next_rand(), next_rand()};
            a = {32'hFFFF_FF00, 22'd0, 7'(i), 3'd0};
            do_access(2'(next_rand()), a, spad_ref[i], 1'b1, 2'd3, rd, flt, lat);
            check_value("spad write latency", 64'(lat), 64'd3);
        end
        for (int i = 0; i < spad_reads; i++) begin
            j = int'(next_rand() % spad_words);
            a = {32'hFFFF_FF00, 22'd0, 7'(j), 3'd0};
            do_access(2'(next_rand()), a, '0, 1'b0, 2'd3, rd, flt, lat);
            check_value("core_rdata", rd, spad_ref[j]);
            check_value("spad read latency", 64'(lat), 64'd3);
            check_value("core_fault", 64'(flt), 64'd0);
        end
        check_value("bus transfers", 64'(bus_count), 64'(bus0));
        report("scratchpad", err0);

        // Test 2: external bus reads and writes with random stalls
        err0 = errors;
        for (int i = 0; i < ext_ops; i++) begin
            c   = 2'(next_rand());
            we  = next_rand() % 32'd2 == 32'd1;
            a   = {32'd0, 4'h1, 28'(next_rand() % 32'h40 * 32'd8)};
            exp = {next_rand(), next_rand()};
            t   = int'(next_rand() % 32'd4);
            bus_addr_q.delete();
            do_access(c, a, exp, we, 2'(t), rd, flt, lat);
            check_value("bus_addr", bus_addr_q.size() == 1 ? bus_addr_q[0] : '1, a);
            check_value("bus_wen", 64'(seen_wen), 64'(we));
            check_value("bus_size", 64'(seen_size), 64'(t));
            if (we) begin
                check_value("bus_wdata", seen_wdata, exp);
            end else begin
                check_value("core_rdata", rd, ext_word(a));
            end
        end
        report("external bus", err0);

        // Test 3: all cores at once, grants rotate after the last one
        err0 = errors;
        for (int r = 0; r < rr_rounds; r++) begin
            // A single access from a random core moves the rotation start
            c = 2'(next_rand());
            do_access(c, {32'hFFFF_FF00, 32'h0}, '0, 1'b0, 2'd3, rd, flt, lat);
            exp_q.delete();
            bus_addr_q.delete();
            for (int i = 0; i < cluster_pkg::num_cores; i++) begin
                rr_addr[i] = {32'd0, 8'h20, 8'(r), 8'(i), 8'h00};
            end
            for (int i = 1; i <= cluster_pkg::num_cores; i++) begin
                exp_q.push_back(rr_addr[2'(rr_last + 2'(i))]);
            end
            fork
                do_access(2'd0, rr_addr[0], '0, 1'b0, 2'd3, rd, flt, lat);
                do_access(2'd1, rr_addr[1], '0, 1'b0, 2'd3, rd, flt, lat);
                do_access(2'd2, rr_addr[2], '0, 1'b0, 2'd3, rd, flt, lat);
                do_access(2'd3, rr_addr[3], '0, 1'b0, 2'd3, rd, flt, lat);
            join
            for (int i = 0; i < cluster_pkg::num_cores; i++) begin
                a = bus_addr_q.size() > i ? bus_addr_q[i] : '1;
                check_value("bus_addr order", a, exp_q[i]);
            end
        end
        report("round robin", err0);

        // Test 4: user mode protection
        err0 = errors;
        csr_write(2'd1, cluster_pkg::csr_mpu_base, 64'h1000_0000);
        csr_write(2'd2, cluster_pkg::csr_mpu_limit, 64'h2000_0000);
        csr_write(2'd0, cluster_pkg::csr_cl_priv, 64'd1);
        csr_write(2'd3, cluster_pkg::csr_mpu_base, 64'd0);
        csr_write(2'd3, cluster_pkg::csr_mpu_limit, 64'hFFFF);
        csr_read(2'd1, cluster_pkg::csr_mpu_base, rd);
        check_value("mpu_base", rd, 64'h1000_0000);
        csr_read(2'd2, cluster_pkg::csr_mpu_limit, rd);
        check_value("mpu_limit", rd, 64'h2000_0000);
        csr_read(2'd3, cluster_pkg::csr_cl_priv, rd);
        check_value("priv", rd, 64'd1);
        do_access(2'd1, {32'hFFFF_FF00, 32'h8}, '0, 1'b0, 2'd3, rd, flt, lat);
        check_value("spad core_fault", 64'(flt), 64'd0);
        check_value("core_rdata", rd, spad_ref[1]);
        do_access(2'd2, {32'hFFFF_FF01, 32'h40}, '0, 1'b0, 2'd3, rd, flt, lat);
        check_value("mmio core_fault", 64'(flt), 64'd0);
        do_access(2'd3, 64'h1000_0040, '0, 1'b0, 2'd3, rd, flt, lat);
        check_value("in-region core_fault", 64'(flt), 64'd0);
        do_access(2'd0, 64'h3000_0000, '0, 1'b0, 2'd3, rd, flt, lat);
        check_value("core_fault", 64'(flt), 64'd1);
        check_value("fault core_rdata", rd, 64'd0);
        check_value("fault latency", 64'(lat), 64'd1);
        csr_read(2'd0, cluster_pkg::csr_cl_priv, rd);
        check_value("priv after fault", rd, 64'd0);
        csr_write(2'd0, cluster_pkg::csr_mpu_limit, 64'd0);
        report("privilege", err0);

        // Test 5: barrier arrivals in random order
        err0 = errors;
        for (int i = 0; i < cluster_pkg::num_cores; i++) begin
            order[i] = 2'(i);
        end
        for (int i = cluster_pkg::num_cores - 1; i > 0; i--) begin
            k = int'(next_rand() % 32'(i + 1));
            c = order[i];
            order[i] = order[k];
            order[k] = c;
        end
        exp = '0;
        done_count = 0;
        for (int i = 0; i < cluster_pkg::num_cores; i++) begin
            csr_write(order[i], cluster_pkg::csr_barrier_arrive, '0);
            exp[order[i]] = 1'b1;
            if (i < cluster_pkg::num_cores - 1) begin
                csr_read(2'(next_rand()), cluster_pkg::csr_barrier_status, rd);
                check_value("barrier status", rd, exp);
            end
        end
        repeat (4) @(posedge clk);
        check_value("barrier_done pulses", 64'(done_count), 64'd1);
        csr_read(2'd0, cluster_pkg::csr_barrier_arrive, rd);
        check_value("arrive mask", rd, 64'd0);
        report("barrier", err0);

        $display("5 tests, %0d failed, %0d errors", tests_failed, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
